/* filelist.f */
src/stim_pkg.sv
src/stim_channel_setup.sv
src/stim_pulse_sequencer.sv
src/stim_electrode_driver.sv
src/stim_top.sv
verif/stim_tb.sv

/* Bender.yml */
package:
  name: stim_ctrl

sources:
  - src/stim_pkg.sv
  - src/stim_channel_setup.sv
  - src/stim_pulse_sequencer.sv
  - src/stim_electrode_driver.sv
  - src/stim_top.sv
  - target: test
    files:
      - verif/stim_tb.sv

/* verif/stim_cases.txt */
# mode ch0 ch1 amp0 amp1 duration rate pulses exp_ca exp_an exp_bcg0 exp_bcg1 exp_dac1
# all columns in hex, one case per line
0 03 05 40 22 02 00 01 08 08 3 0 00
1 02 06 80 11 03 00 01 04 40 2 0 00
2 01 04 33 55 02 00 01 12 12 1 4 55
1 00 01 10 20 01 00 01 01 02 0 2 00
0 00 00 7f 01 00 00 01 01 01 0 1 00
3 06 02 25 44 01 00 01 40 40 6 0 00
1 09 01 5a 66 02 00 01 01 02 0 2 00
2 0c 07 91 a5 01 00 01 81 81 0 7 a5
0 01 00 12 34 00 00 01 02 02 1 2 00
1 04 05 c8 01 02 03 03 10 20 4 0 00
2 00 02 50 60 01 02 02 05 05 0 2 60
0 07 ff 0f f0 00 01 03 80 80 7 1 00
2 05 05 3c 4d 00 00 01 20 20 5 5 4d
1 07 06 01 02 02 00 01 80 40 7 0 00
1 02 03 aa bb 05 00 01 04 08 2 0 00

/* verif/stim_tb.sv */
`timescale 1ns/1ps

module stim_tb;

	localparam int RESET_CYCLES = 3;
	localparam int GAP_CYCLES   = 2;
	localparam int MAX_CASES    = 32;
	localparam int N_COLS       = 13;
	localparam int COL_MODE     = 0;
	localparam int COL_CH0      = 1;
	localparam int COL_CH1      = 2;
	localparam int COL_AMP0     = 3;
	localparam int COL_AMP1     = 4;
	localparam int COL_DUR      = 5;
	localparam int COL_RATE     = 6;
	localparam int COL_PULSES   = 7;
	localparam int COL_CA       = 8;
	localparam int COL_AN       = 9;
	localparam int COL_BCG0     = 10;
	localparam int COL_BCG1     = 11;
	localparam int COL_DAC1     = 12;

	logic       i_clk;
	logic       i_rst_n;
	logic       i_trigger;
	logic [1:0] i_polarity;
	logic [7:0] i_channel_0;
	logic [7:0] i_channel_1;
	logic [7:0] i_dac_amp_0;
	logic [7:0] i_dac_amp_1;
	logic [7:0] i_duration;
	logic [7:0] i_rate;
	logic [7:0] o_stim_ca;
	logic [7:0] o_stim_an;
	logic [7:0] o_stim_dac0_val;
	logic [7:0] o_stim_dac1_val;
	logic [2:0] o_stim_bcg0_sel;
	logic [2:0] o_stim_bcg1_sel;
	logic       o_stim_comp_en_n;

	int case_tab [0:MAX_CASES-1][0:N_COLS-1];
	int n_cases;
	int error_count;
	int check_count;
	int cycle_count;
	int cycle_limit;

	stim_top uut (
		.i_clk            (i_clk),
		.i_rst_n          (i_rst_n),
		.i_trigger        (i_trigger),
		.i_polarity       (i_polarity),
		.i_channel_0      (i_channel_0),
		.i_channel_1      (i_channel_1),
		.i_dac_amp_0      (i_dac_amp_0),
		.i_dac_amp_1      (i_dac_amp_1),
		.i_duration       (i_duration),
		.i_rate           (i_rate),
		.o_stim_ca        (o_stim_ca),
		.o_stim_an        (o_stim_an),
		.o_stim_dac0_val  (o_stim_dac0_val),
		.o_stim_dac1_val  (o_stim_dac1_val),
		.o_stim_bcg0_sel  (o_stim_bcg0_sel),
		.o_stim_bcg1_sel  (o_stim_bcg1_sel),
		.o_stim_comp_en_n (o_stim_comp_en_n)
	);

	always #4 i_clk = ~i_clk;

	always @(posedge i_clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout: run stopped after %0d clock cycles", cycle_count);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic load_cases();
		int fd;
		int n;
		string line;
		int row [0:N_COLS-1];
		n_cases = 0;
		fd = $fopen("verif/stim_cases.txt", "r");
		if (fd == 0)
		begin
			$display("could not open verif/stim_cases.txt");
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			// comments and blank lines.
			if (line.len() < 2 || line.getc(0) == "#")
			begin
				continue;
			end
			n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", row[0], row[1],
				row[2], row[3], row[4], row[5], row[6], row[7], row[8], row[9], row[10],
				row[11], row[12]);
			if (n != N_COLS || n_cases >= MAX_CASES)
			begin
				$display("case line not used, wrong column count or table full: %s", line);
				error_count++;
			end
			else
			begin
				for (int c = 0; c < N_COLS; c++)
				begin
					case_tab[n_cases][c] = row[c];
				end
				n_cases++;
			end
		end
		$fclose(fd);
	endtask

	// budget per case plus the aborted and the fresh train of the abort test.
	task automatic set_cycle_limit();
		int sum;
		int last;
		sum = RESET_CYCLES + 4;
		for (int i = 0; i < n_cases; i++)
		begin
			sum += 10 + case_tab[i][COL_PULSES] *
				(2 * case_tab[i][COL_DUR] + case_tab[i][COL_RATE] + 8);
		end
		last = n_cases - 1;
		sum += 10 + 2 * case_tab[last][COL_DUR] + case_tab[last][COL_RATE] + 8;
		sum += 10 + 2 * case_tab[0][COL_DUR] + case_tab[0][COL_RATE] + 8;
		cycle_limit = sum;
	endtask

	task automatic drive_settings(input int idx);
		i_polarity  = 2'(case_tab[idx][COL_MODE]);
		i_channel_0 = 8'(case_tab[idx][COL_CH0]);
		i_channel_1 = 8'(case_tab[idx][COL_CH1]);
		i_dac_amp_0 = 8'(case_tab[idx][COL_AMP0]);
		i_dac_amp_1 = 8'(case_tab[idx][COL_AMP1]);
		i_duration  = 8'(case_tab[idx][COL_DUR]);
		i_rate      = 8'(case_tab[idx][COL_RATE]);
		i_trigger   = 1'b1;
	endtask

	task automatic wait_first_cathode();
		while (o_stim_ca == '0)
		begin
			check_value("anode mask during search", o_stim_an, 0);
			@(negedge i_clk);
		end
	endtask

	task automatic check_loads(input int idx);
		check_value("dac0", o_stim_dac0_val, case_tab[idx][COL_AMP0]);
		check_value("dac1", o_stim_dac1_val, case_tab[idx][COL_DAC1]);
		check_value("bcg0 select", o_stim_bcg0_sel, case_tab[idx][COL_BCG0]);
		check_value("bcg1 select", o_stim_bcg1_sel, case_tab[idx][COL_BCG1]);
	endtask

	// starts on the first cathodic sample and ends on the first sample after the anode.
	task automatic measure_pulse(input int exp_ca, input int exp_an, input int dur);
		int count;
		count = 0;
		while (o_stim_ca != '0)
		begin
			check_value("cathode mask", o_stim_ca, exp_ca);
			check_value("anode mask in cathodic phase", o_stim_an, 0);
			check_value("monitor enable in cathodic phase", o_stim_comp_en_n, 0);
			count++;
			@(negedge i_clk);
		end
		check_value("cathodic cycles", count, dur + 1);
		count = 0;
		while (o_stim_an == '0)
		begin
			check_value("cathode mask in gap", o_stim_ca, 0);
			check_value("monitor enable in gap", o_stim_comp_en_n, 0);
			count++;
			@(negedge i_clk);
		end
		check_value("gap cycles", count, GAP_CYCLES);
		count = 0;
		while (o_stim_an != '0)
		begin
			check_value("anode mask", o_stim_an, exp_an);
			check_value("cathode mask in anodic phase", o_stim_ca, 0);
			check_value("monitor enable in anodic phase", o_stim_comp_en_n, 0);
			count++;
			@(negedge i_clk);
		end
		check_value("anodic cycles", count, dur + 1);
		check_value("monitor enable after pulse", o_stim_comp_en_n, 1);
	endtask

	task automatic measure_rest(input int rate);
		int count;
		count = 0;
		while (o_stim_ca == '0)
		begin
			check_value("anode mask in rest", o_stim_an, 0);
			check_value("monitor enable in rest", o_stim_comp_en_n, 1);
			count++;
			@(negedge i_clk);
		end
		check_value("rest cycles", count, rate + 1);
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles)
		begin
			check_value("idle cathode mask", o_stim_ca, 0);
			check_value("idle anode mask", o_stim_an, 0);
			check_value("idle monitor enable", o_stim_comp_en_n, 1);
			@(negedge i_clk);
		end
	endtask

	task automatic run_case(input int idx);
		int pulses;
		int rate;
		pulses = case_tab[idx][COL_PULSES];
		rate   = case_tab[idx][COL_RATE];
		drive_settings(idx);
		@(negedge i_clk);
		i_trigger = 1'b0;
		wait_first_cathode();
		check_loads(idx);
		for (int p = 0; p < pulses; p++)
		begin
			measure_pulse(case_tab[idx][COL_CA], case_tab[idx][COL_AN], case_tab[idx][COL_DUR]);
			if (p < pulses - 1)
			begin
				measure_rest(rate);
			end
		end
		if (rate == 0)
		begin
			check_idle(3);
		end
	endtask

	// retrigger with other settings on the first cathodic cycle, then expect their pulse.
	task automatic run_abort(input int first_idx, input int next_idx);
		drive_settings(first_idx);
		@(negedge i_clk);
		i_trigger = 1'b0;
		wait_first_cathode();
		drive_settings(next_idx);
		@(negedge i_clk);
		i_trigger = 1'b0;
		@(negedge i_clk);
		check_value("cathode mask after abort", o_stim_ca, 0);
		check_value("anode mask after abort", o_stim_an, 0);
		check_value("monitor enable after abort", o_stim_comp_en_n, 1);
		wait_first_cathode();
		check_loads(next_idx);
		measure_pulse(case_tab[next_idx][COL_CA], case_tab[next_idx][COL_AN],
			case_tab[next_idx][COL_DUR]);
	endtask

	initial
	begin
		i_clk       = 1'b0;
		i_rst_n     = 1'b0;
		i_trigger   = 1'b0;
		i_polarity  = '0;
		i_channel_0 = '0;
		i_channel_1 = '0;
		i_dac_amp_0 = '0;
		i_dac_amp_1 = '0;
		i_duration  = '0;
		i_rate      = '0;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		cycle_limit = 0;
		load_cases();
		if (n_cases == 0)
		begin
			$display("no test cases were read, nothing to run");
			$display("SOME TESTS FAILED");
			$finish;
		end
		else
		begin
			set_cycle_limit();
			repeat (RESET_CYCLES) @(posedge i_clk);
			@(negedge i_clk);
			i_rst_n = 1'b1;
			@(negedge i_clk);
			check_value("reset cathode mask", o_stim_ca, 0);
			check_value("reset anode mask", o_stim_an, 0);
			check_value("reset dac0", o_stim_dac0_val, 0);
			check_value("reset dac1", o_stim_dac1_val, 0);
			check_value("reset bcg0 select", o_stim_bcg0_sel, 0);
			check_value("reset bcg1 select", o_stim_bcg1_sel, 0);
			check_value("reset monitor enable", o_stim_comp_en_n, 1);
			for (int i = 0; i < n_cases; i++)
			begin
				run_case(i);
			end
			run_abort(n_cases - 1, 0);
			$display("%0d cases, %0d checks, %0d errors", n_cases, check_count, error_count);
			if (error_count == 0)
			begin
				$display("ALL TESTS PASSED");
			end
			else
			begin
				$display("SOME TESTS FAILED");
			end
			$finish;
		end
	end

endmodule

/* src/stim_top.sv */
`timescale 1ns/1ps

module stim_top #(
	parameter int INTERVAL_CYCLES = 2
) (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_trigger,
	input  logic [1:0]                i_polarity,
	input  stim_pkg::channel_t        i_channel_0,
	input  stim_pkg::channel_t        i_channel_1,
	input  stim_pkg::dac_amp_t        i_dac_amp_0,
	input  stim_pkg::dac_amp_t        i_dac_amp_1,
	input  stim_pkg::count_t          i_duration,
	input  stim_pkg::count_t          i_rate,
	output stim_pkg::electrode_mask_t o_stim_ca,
	output stim_pkg::electrode_mask_t o_stim_an,
	output stim_pkg::dac_amp_t        o_stim_dac0_val,
	output stim_pkg::dac_amp_t        o_stim_dac1_val,
	output stim_pkg::electrode_sel_t  o_stim_bcg0_sel,
	output stim_pkg::electrode_sel_t  o_stim_bcg1_sel,
	output logic                      o_stim_comp_en_n
);

	stim_pkg::stim_mode_t      w_mode;
	stim_pkg::electrode_mask_t w_cathode_mask;
	stim_pkg::electrode_mask_t w_anode_mask;
	stim_pkg::dac_amp_t        w_amp_0;
	stim_pkg::dac_amp_t        w_amp_1;
	stim_pkg::electrode_sel_t  w_sel_0;
	stim_pkg::electrode_sel_t  w_sel_1;
	logic                      w_search_done;
	logic                      w_cathode_on;
	logic                      w_anode_on;
	logic                      w_pulse_active;
	logic                      w_load;

	stim_channel_setup u_setup (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_trigger      (i_trigger),
		.i_polarity     (i_polarity),
		.i_channel_0    (i_channel_0),
		.i_channel_1    (i_channel_1),
		.i_dac_amp_0    (i_dac_amp_0),
		.i_dac_amp_1    (i_dac_amp_1),
		.o_mode         (w_mode),
		.o_cathode_mask (w_cathode_mask),
		.o_anode_mask   (w_anode_mask),
		.o_amp_0        (w_amp_0),
		.o_amp_1        (w_amp_1),
		.o_sel_0        (w_sel_0),
		.o_sel_1        (w_sel_1),
		.o_search_done  (w_search_done)
	);

	stim_pulse_sequencer #(
		.INTERVAL_CYCLES (INTERVAL_CYCLES)
	) u_seq (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_trigger      (i_trigger),
		.i_mode         (w_mode),
		.i_duration     (i_duration),
		.i_rate         (i_rate),
		.i_search_done  (w_search_done),
		.o_cathode_on   (w_cathode_on),
		.o_anode_on     (w_anode_on),
		.o_pulse_active (w_pulse_active),
		.o_load         (w_load)
	);

	stim_electrode_driver u_drv (
		.i_clk            (i_clk),
		.i_rst_n          (i_rst_n),
		.i_cathode_on     (w_cathode_on),
		.i_anode_on       (w_anode_on),
		.i_pulse_active   (w_pulse_active),
		.i_load           (w_load),
		.i_cathode_mask   (w_cathode_mask),
		.i_anode_mask     (w_anode_mask),
		.i_amp_0          (w_amp_0),
		.i_amp_1          (w_amp_1),
		.i_sel_0          (w_sel_0),
		.i_sel_1          (w_sel_1),
		.o_stim_ca        (o_stim_ca),
		.o_stim_an        (o_stim_an),
		.o_stim_dac0_val  (o_stim_dac0_val),
		.o_stim_dac1_val  (o_stim_dac1_val),
		.o_stim_bcg0_sel  (o_stim_bcg0_sel),
		.o_stim_bcg1_sel  (o_stim_bcg1_sel),
		.o_stim_comp_en_n (o_stim_comp_en_n)
	);

endmodule

/* src/stim_electrode_driver.sv */
`timescale 1ns/1ps

module stim_electrode_driver (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_cathode_on,
	input  logic                      i_anode_on,
	input  logic                      i_pulse_active,
	input  logic                      i_load,
	input  stim_pkg::electrode_mask_t i_cathode_mask,
	input  stim_pkg::electrode_mask_t i_anode_mask,
	input  stim_pkg::dac_amp_t        i_amp_0,
	input  stim_pkg::dac_amp_t        i_amp_1,
	input  stim_pkg::electrode_sel_t  i_sel_0,
	input  stim_pkg::electrode_sel_t  i_sel_1,
	output stim_pkg::electrode_mask_t o_stim_ca,
	output stim_pkg::electrode_mask_t o_stim_an,
	output stim_pkg::dac_amp_t        o_stim_dac0_val,
	output stim_pkg::dac_amp_t        o_stim_dac1_val,
	output stim_pkg::electrode_sel_t  o_stim_bcg0_sel,
	output stim_pkg::electrode_sel_t  o_stim_bcg1_sel,
	output logic                      o_stim_comp_en_n
);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_stim_ca        <= '0;
			o_stim_an        <= '0;
			o_stim_comp_en_n <= 1'b1;
		end
		else
		begin
			o_stim_ca        <= i_cathode_on ? i_cathode_mask : '0;
			o_stim_an        <= i_anode_on ? i_anode_mask : '0;
			// monitor is enabled low for the whole pulse.
			o_stim_comp_en_n <= !i_pulse_active;
		end
	end

	// dac values and selects hold between loads.
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_stim_dac0_val <= '0;
			o_stim_dac1_val <= '0;
			o_stim_bcg0_sel <= '0;
			o_stim_bcg1_sel <= '0;
		end
		else if (i_load)
		begin
			o_stim_dac0_val <= i_amp_0;
			o_stim_dac1_val <= i_amp_1;
			o_stim_bcg0_sel <= i_sel_0;
			o_stim_bcg1_sel <= i_sel_1;
		end
	end

	a_masks_exclusive: assert property (
		@(posedge i_clk) disable iff (!i_rst_n) !((|o_stim_ca) && (|o_stim_an))
	);

endmodule

/* src/stim_pulse_sequencer.sv */
`timescale 1ns/1ps

module stim_pulse_sequencer #(
	parameter int INTERVAL_CYCLES = 2
) (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_trigger,
	input  stim_pkg::stim_mode_t i_mode,
	input  stim_pkg::count_t     i_duration,
	input  stim_pkg::count_t     i_rate,
	input  logic                 i_search_done,
	output logic                 o_cathode_on,
	output logic                 o_anode_on,
	output logic                 o_pulse_active,
	output logic                 o_load
);

	// last count of the gap between the two phases.
	localparam stim_pkg::count_t GAP_LAST = stim_pkg::count_t'(INTERVAL_CYCLES - 1);

	stim_pkg::seq_state_t r_state;
	stim_pkg::seq_state_t c_next_state;
	stim_pkg::count_t     r_duration;
	stim_pkg::count_t     r_rate;
	stim_pkg::count_t     r_phase_cnt;
	stim_pkg::count_t     r_rate_cnt;
	logic                 w_phase_end;
	logic                 w_gap_end;
	logic                 w_rest_end;
	logic                 w_in_pulse;

	always_ff @(posedge i_clk)
	begin
		if (i_trigger)
		begin
			r_duration <= i_duration;
			r_rate     <= i_rate;
		end
	end

	assign w_phase_end = (r_phase_cnt == r_duration);
	assign w_gap_end   = (r_phase_cnt == GAP_LAST);
	assign w_rest_end  = (r_rate_cnt == r_rate);

	// a trigger in any state restarts from the search.
	always_comb
	begin
		c_next_state = r_state;
		if (i_trigger)
		begin
			c_next_state = stim_pkg::SEQ_SEARCH;
		end
		else
		begin
			case (r_state)
				stim_pkg::SEQ_IDLE:
				begin
					c_next_state = stim_pkg::SEQ_IDLE;
				end
				stim_pkg::SEQ_SEARCH:
				begin
					if (i_search_done)
					begin
						c_next_state = stim_pkg::SEQ_CATHODE;
					end
				end
				stim_pkg::SEQ_CATHODE:
				begin
					if (w_phase_end)
					begin
						c_next_state = stim_pkg::SEQ_GAP;
					end
				end
				stim_pkg::SEQ_GAP:
				begin
					if (w_gap_end)
					begin
						c_next_state = stim_pkg::SEQ_ANODE;
					end
				end
				stim_pkg::SEQ_ANODE:
				begin
					if (w_phase_end)
					begin
						c_next_state = (r_rate == '0) ? stim_pkg::SEQ_IDLE : stim_pkg::SEQ_REST;
					end
				end
				stim_pkg::SEQ_REST:
				begin
					if (w_rest_end)
					begin
						c_next_state = stim_pkg::SEQ_CATHODE;
					end
				end
				default:
				begin
					c_next_state = stim_pkg::SEQ_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			r_state     <= stim_pkg::SEQ_IDLE;
			r_phase_cnt <= '0;
			r_rate_cnt  <= '0;
		end
		else
		begin
			r_state <= c_next_state;
			// one counter serves cathode, gap and anode.
			if (c_next_state != r_state)
			begin
				r_phase_cnt <= '0;
			end
			else
			begin
				r_phase_cnt <= r_phase_cnt + 1'b1;
			end
			if (r_state == stim_pkg::SEQ_REST && c_next_state == stim_pkg::SEQ_REST)
			begin
				r_rate_cnt <= r_rate_cnt + 1'b1;
			end
			else
			begin
				r_rate_cnt <= '0;
			end
		end
	end

	assign w_in_pulse = (r_state == stim_pkg::SEQ_CATHODE) || (r_state == stim_pkg::SEQ_GAP) ||
		(r_state == stim_pkg::SEQ_ANODE);

	// levels trail the state by a cycle and drop at once on a trigger.
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_cathode_on   <= 1'b0;
			o_anode_on     <= 1'b0;
			o_pulse_active <= 1'b0;
			o_load         <= 1'b0;
		end
		else
		begin
			o_cathode_on   <= !i_trigger && (r_state == stim_pkg::SEQ_CATHODE);
			o_anode_on     <= !i_trigger && (r_state == stim_pkg::SEQ_ANODE);
			o_pulse_active <= !i_trigger && w_in_pulse;
			o_load         <= !i_trigger && (r_state == stim_pkg::SEQ_CATHODE) && !o_cathode_on;
		end
	end

	a_phases_exclusive: assert property (
		@(posedge i_clk) disable iff (!i_rst_n) !(o_cathode_on && o_anode_on)
	);

	// a pulse is loaded with one of the three decoded modes.
	a_mode_legal: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		o_load |-> (i_mode inside {stim_pkg::MODE_MONOPOLAR, stim_pkg::MODE_BIPOLAR,
			stim_pkg::MODE_SIMULTANEOUS})
	);

endmodule

/* src/stim_channel_setup.sv */
`timescale 1ns/1ps

module stim_channel_setup (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_trigger,
	input  logic [1:0]                i_polarity,
	input  stim_pkg::channel_t        i_channel_0,
	input  stim_pkg::channel_t        i_channel_1,
	input  stim_pkg::dac_amp_t        i_dac_amp_0,
	input  stim_pkg::dac_amp_t        i_dac_amp_1,
	output stim_pkg::stim_mode_t      o_mode,
	output stim_pkg::electrode_mask_t o_cathode_mask,
	output stim_pkg::electrode_mask_t o_anode_mask,
	output stim_pkg::dac_amp_t        o_amp_0,
	output stim_pkg::dac_amp_t        o_amp_1,
	output stim_pkg::electrode_sel_t  o_sel_0,
	output stim_pkg::electrode_sel_t  o_sel_1,
	output logic                      o_search_done
);

	stim_pkg::stim_mode_t      r_mode;
	stim_pkg::electrode_sel_t  r_elec_0;
	stim_pkg::electrode_sel_t  r_elec_1;
	stim_pkg::dac_amp_t        r_amp_0;
	stim_pkg::dac_amp_t        r_amp_1;
	stim_pkg::electrode_mask_t r_search_ptr;
	logic                      r_search_busy;
	stim_pkg::electrode_mask_t w_mask_0;
	stim_pkg::electrode_mask_t w_mask_1;
	stim_pkg::electrode_mask_t w_union;
	logic                      w_found;

	// out of range numbers fall back to electrode 0.
	function automatic stim_pkg::electrode_sel_t channel_to_sel(input stim_pkg::channel_t ch);
		if (ch < stim_pkg::N_ELECTRODES)
		begin
			return ch[2:0];
		end
		return '0;
	endfunction

	function automatic stim_pkg::electrode_sel_t mask_to_sel(
		input stim_pkg::electrode_mask_t mask
	);
		stim_pkg::electrode_sel_t sel;
		sel = '0;
		for (int i = 0; i < stim_pkg::N_ELECTRODES; i++)
		begin
			if (mask[i])
			begin
				sel = stim_pkg::electrode_sel_t'(i);
			end
		end
		return sel;
	endfunction

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			r_mode <= stim_pkg::MODE_MONOPOLAR;
		end
		else if (i_trigger)
		begin
			case (i_polarity)
				2'd1:    r_mode <= stim_pkg::MODE_BIPOLAR;
				2'd2:    r_mode <= stim_pkg::MODE_SIMULTANEOUS;
				default: r_mode <= stim_pkg::MODE_MONOPOLAR;
			endcase
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_trigger)
		begin
			r_elec_0 <= channel_to_sel(i_channel_0);
			r_elec_1 <= channel_to_sel(i_channel_1);
			r_amp_0  <= i_dac_amp_0;
			r_amp_1  <= i_dac_amp_1;
		end
	end

	assign w_mask_0 = stim_pkg::electrode_mask_t'(1) << r_elec_0;
	assign w_mask_1 = stim_pkg::electrode_mask_t'(1) << r_elec_1;
	assign w_union  = w_mask_0 | w_mask_1;

	always_comb
	begin
		case (r_mode)
			stim_pkg::MODE_BIPOLAR:
			begin
				o_cathode_mask = w_mask_0;
				o_anode_mask   = w_mask_1;
			end
			stim_pkg::MODE_SIMULTANEOUS:
			begin
				o_cathode_mask = w_union;
				o_anode_mask   = w_union;
			end
			default:
			begin
				o_cathode_mask = w_mask_0;
				o_anode_mask   = w_mask_0;
			end
		endcase
	end

	// walk one electrode per cycle from electrode 0 until a free one is hit.
	assign w_found = |(r_search_ptr & ~w_union);

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			r_search_ptr  <= stim_pkg::electrode_mask_t'(1);
			r_search_busy <= 1'b0;
		end
		else if (i_trigger)
		begin
			r_search_ptr  <= stim_pkg::electrode_mask_t'(1);
			r_search_busy <= 1'b1;
		end
		else if (r_search_busy)
		begin
			if (w_found)
			begin
				r_search_busy <= 1'b0;
			end
			else
			begin
				r_search_ptr <= {r_search_ptr[stim_pkg::N_ELECTRODES-2:0],
					r_search_ptr[stim_pkg::N_ELECTRODES-1]};
			end
		end
	end

	assign o_search_done = r_search_busy & w_found;

	assign o_mode  = r_mode;
	assign o_amp_0 = r_amp_0;
	assign o_amp_1 = (r_mode == stim_pkg::MODE_SIMULTANEOUS) ? r_amp_1 : '0;
	assign o_sel_0 = r_elec_0;
	assign o_sel_1 = (r_mode == stim_pkg::MODE_SIMULTANEOUS) ? r_elec_1 : mask_to_sel(r_search_ptr);

	a_search_ptr_onehot: assert property (
		@(posedge i_clk) disable iff (!i_rst_n) $onehot(r_search_ptr)
	);

endmodule

/* src/stim_pkg.sv */
package stim_pkg;

	// electrode array size.
	localparam int N_ELECTRODES = 8;

	typedef logic [N_ELECTRODES-1:0] electrode_mask_t;

	// number of one electrode that drives a current generator select.
	typedef logic [2:0] electrode_sel_t;

	// raw electrode number where values above 7 select electrode 0.
	typedef logic [7:0] channel_t;

	typedef logic [7:0] dac_amp_t;

	// durations, rates and timer counts in clock cycles.
	typedef logic [7:0] count_t;

	typedef enum logic [1:0] {
		MODE_MONOPOLAR    = 2'd0,
		MODE_BIPOLAR      = 2'd1,
		MODE_SIMULTANEOUS = 2'd2
	} stim_mode_t;

	typedef enum logic [2:0] {
		SEQ_IDLE    = 3'd0,
		SEQ_SEARCH  = 3'd1,
		SEQ_CATHODE = 3'd2,
		SEQ_GAP     = 3'd3,
		SEQ_ANODE   = 3'd4,
		SEQ_REST    = 3'd5
	} seq_state_t;

endpackage
